// File: include/vehicle_consts.svh
`ifndef VEHICLE_CONSTS_SVH
`define VEHICLE_CONSTS_SVH

// ====================
// engine and throttle
// ====================
`define VEH_IDLE_RPM        800
`define VEH_DEAD_ZONE       5
`define VEH_RELEASE_STEP    8
`define VEH_IDLE_ACCEL_GAIN 20
`define VEH_IDLE_RPM_MAX    4000
`define VEH_DRIVE_RPM_MAX   8000
`define VEH_REDLINE_GATE    7900
`define VEH_RPM_BASE_MAX    10000

// per-gear rpm per km/h
`define VEH_RPM_FACTOR_G1   100
`define VEH_RPM_FACTOR_G2   60
`define VEH_RPM_FACTOR_G3   40
`define VEH_RPM_FACTOR_G4   30
`define VEH_RPM_FACTOR_G5   24
`define VEH_RPM_FACTOR_G6   18

// ====================
// speed limits and resistance
// ====================
`define VEH_TOP_SPEED       250
`define VEH_REV_SPEED_MAX   50
`define VEH_ESS_SPEED       50
`define VEH_ROLL_RES        5
`define VEH_AIR_DRAG        100
`define VEH_AIR_DRAG_SPEED  180

// brake steps in km/h per tick, banded by speed
`define VEH_BRAKE_BAND_HI   150
`define VEH_BRAKE_BAND_MID  80
`define VEH_HARD_STEP_HI    2
`define VEH_HARD_STEP_MID   4
`define VEH_HARD_STEP_LO    8
`define VEH_NORM_STEP_HI    1
`define VEH_NORM_STEP_MID   2
`define VEH_NORM_STEP_LO    3

// ====================
// shift points and coast drag
// ====================
// downshift points, upshift sits one hysteresis step above
`define VEH_SHIFT_12        20
`define VEH_SHIFT_23        31
`define VEH_SHIFT_34        50
`define VEH_SHIFT_45        71
`define VEH_SHIFT_56        105
`define VEH_SHIFT_HYST      5

// ticks per 1 km/h lost while coasting
`define VEH_DRAG_G1         1
`define VEH_DRAG_G2         3
`define VEH_DRAG_G3         6
`define VEH_DRAG_G4         10
`define VEH_DRAG_G5_FAST    8
`define VEH_DRAG_G5_SLOW    15
`define VEH_DRAG_G5_SPEED   120
`define VEH_DRAG_G6_FAST    2
`define VEH_DRAG_G6_MID     5
`define VEH_DRAG_G6_SLOW    20
`define VEH_DRAG_G6_SPEED_HI  170
`define VEH_DRAG_G6_SPEED_MID 140

`endif

// File: source/vehicle_pkg.sv
`default_nettype none

package vehicle_pkg;

    // ====================
    // selector and widths
    // ====================
    // selector encoding matches the shifter switch codes
    typedef enum logic [3:0] {
        SEL_P = 4'd3,
        SEL_R = 4'd6,
        SEL_N = 4'd9,
        SEL_D = 4'd12
    } gear_sel_e;

    // km/h
    typedef logic [7:0]  speed_t;
    typedef logic [13:0] rpm_t;
    // raw pedal adc value
    typedef logic [7:0]  accel_t;
    // gear 1 to 6
    typedef logic [2:0]  gear_t;

    // ====================
    // driver controls
    // ====================
    typedef struct packed {
        logic      engine_on;
        gear_sel_e selector;
        accel_t    accel;
        logic      brake_normal;
        logic      brake_hard;
    } driver_s;

endpackage

`default_nettype wire

// File: source/throttle_filter.sv
`timescale 1ns/10ps
`default_nettype none

`include "vehicle_consts.svh"

module throttle_filter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  tick_speed,
    input  vehicle_pkg::accel_t  accel,
    output vehicle_pkg::accel_t  eff_accel,
    output vehicle_pkg::accel_t  smooth_accel,
    output logic [1:0]           jitter
);

    // small pedal readings are adc noise, treat them as released
    always_comb begin
        if (accel > vehicle_pkg::accel_t'(`VEH_DEAD_ZONE)) begin
            eff_accel = accel - vehicle_pkg::accel_t'(`VEH_DEAD_ZONE);
        end else begin
            eff_accel = '0;
        end
    end

    // ====================
    // smoothing and jitter
    // ====================
    // press is followed at once, release only in steps so rpm sags slowly
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            smooth_accel <= '0;
            jitter       <= '0;
        end else if (tick_speed) begin
            jitter <= jitter + 2'd1;
            if (eff_accel > smooth_accel) begin
                smooth_accel <= eff_accel;
            end else if (eff_accel < smooth_accel) begin
                if (smooth_accel >= vehicle_pkg::accel_t'(`VEH_RELEASE_STEP)) begin
                    smooth_accel <= smooth_accel - vehicle_pkg::accel_t'(`VEH_RELEASE_STEP);
                end else begin
                    // close to the target, no room for another full step
                    smooth_accel <= eff_accel;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/speed_dynamics.sv
`timescale 1ns/10ps
`default_nettype none

`include "vehicle_consts.svh"

module speed_dynamics (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   tick_speed,
    input  vehicle_pkg::driver_s  driver,
    input  vehicle_pkg::accel_t   eff_accel,
    input  vehicle_pkg::gear_t    gear,
    input  vehicle_pkg::rpm_t     rpm,
    output vehicle_pkg::speed_t   speed,
    output logic                  ess,
    output logic                  coast_step
);

    logic [9:0]          power;
    logic [9:0]          resistance;
    vehicle_pkg::speed_t brake_step;
    vehicle_pkg::speed_t braked_speed;
    logic                accel_ok;
    logic [4:0]          drag_interval;
    logic [4:0]          drag_cnt;

    // ====================
    // force balance
    // ====================
    always_comb begin
        power = '0;
        if (driver.engine_on && driver.selector == vehicle_pkg::SEL_D) begin
            power = {2'b00, eff_accel};
        end else if (driver.engine_on && driver.selector == vehicle_pkg::SEL_R) begin
            // reverse gets half the drive
            power = {3'b000, eff_accel[7:1]};
        end

        resistance = {2'b00, speed} + 10'(`VEH_ROLL_RES);
        if (speed >= vehicle_pkg::speed_t'(`VEH_AIR_DRAG_SPEED)) begin
            resistance = resistance + 10'(`VEH_AIR_DRAG);
        end
    end

    // no gain past top speed, redline, or the reverse limit
    assign accel_ok = (speed < vehicle_pkg::speed_t'(`VEH_TOP_SPEED)) &&
                      (rpm < vehicle_pkg::rpm_t'(`VEH_REDLINE_GATE)) &&
                      !(driver.selector == vehicle_pkg::SEL_R &&
                        speed >= vehicle_pkg::speed_t'(`VEH_REV_SPEED_MAX));

    // ====================
    // brake step
    // ====================
    // hard brake bites less at high speed, the tyres slide
    always_comb begin
        if (driver.brake_hard) begin
            if (speed > vehicle_pkg::speed_t'(`VEH_BRAKE_BAND_HI)) begin
                brake_step = vehicle_pkg::speed_t'(`VEH_HARD_STEP_HI);
            end else if (speed > vehicle_pkg::speed_t'(`VEH_BRAKE_BAND_MID)) begin
                brake_step = vehicle_pkg::speed_t'(`VEH_HARD_STEP_MID);
            end else begin
                brake_step = vehicle_pkg::speed_t'(`VEH_HARD_STEP_LO);
            end
        end else begin
            if (speed > vehicle_pkg::speed_t'(`VEH_BRAKE_BAND_HI)) begin
                brake_step = vehicle_pkg::speed_t'(`VEH_NORM_STEP_HI);
            end else if (speed > vehicle_pkg::speed_t'(`VEH_BRAKE_BAND_MID)) begin
                brake_step = vehicle_pkg::speed_t'(`VEH_NORM_STEP_MID);
            end else begin
                brake_step = vehicle_pkg::speed_t'(`VEH_NORM_STEP_LO);
            end
        end
        braked_speed = (speed >= brake_step) ? speed - brake_step : '0;
    end

    // coast drag interval, gears 5 and 6 lose speed faster when fast
    always_comb begin
        case (gear)
            3'd1: drag_interval = 5'(`VEH_DRAG_G1);
            3'd2: drag_interval = 5'(`VEH_DRAG_G2);
            3'd3: drag_interval = 5'(`VEH_DRAG_G3);
            3'd4: drag_interval = 5'(`VEH_DRAG_G4);
            3'd5: begin
                if (speed >= vehicle_pkg::speed_t'(`VEH_DRAG_G5_SPEED)) begin
                    drag_interval = 5'(`VEH_DRAG_G5_FAST);
                end else begin
                    drag_interval = 5'(`VEH_DRAG_G5_SLOW);
                end
            end
            3'd6: begin
                if (speed >= vehicle_pkg::speed_t'(`VEH_DRAG_G6_SPEED_HI)) begin
                    drag_interval = 5'(`VEH_DRAG_G6_FAST);
                end else if (speed >= vehicle_pkg::speed_t'(`VEH_DRAG_G6_SPEED_MID)) begin
                    drag_interval = 5'(`VEH_DRAG_G6_MID);
                end else begin
                    drag_interval = 5'(`VEH_DRAG_G6_SLOW);
                end
            end
            default: drag_interval = 5'(`VEH_DRAG_G1);
        endcase
    end

    // ====================
    // speed update
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed      <= '0;
            ess        <= 1'b0;
            drag_cnt   <= '0;
            coast_step <= 1'b0;
        end else begin
            // lets the gear selector see the freshly updated speed
            coast_step <= tick_speed && !driver.brake_hard && !driver.brake_normal;
            if (tick_speed) begin
                if (driver.brake_hard) begin
                    speed <= braked_speed;
                    ess   <= speed > vehicle_pkg::speed_t'(`VEH_ESS_SPEED);
                end else if (driver.brake_normal) begin
                    speed <= braked_speed;
                    ess   <= 1'b0;
                end else begin
                    ess <= 1'b0;
                    if (power > resistance) begin
                        drag_cnt <= '0;
                        if (accel_ok) begin
                            speed <= speed + 8'd1;
                        end
                    end else if (power < resistance) begin
                        if (speed == '0) begin
                            drag_cnt <= '0;
                        end else if (drag_cnt >= drag_interval) begin
                            speed    <= speed - 8'd1;
                            drag_cnt <= '0;
                        end else begin
                            drag_cnt <= drag_cnt + 5'd1;
                        end
                    end else begin
                        drag_cnt <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/gear_selector.sv
`timescale 1ns/10ps
`default_nettype none

`include "vehicle_consts.svh"

module gear_selector (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    coast_step,
    input  vehicle_pkg::gear_sel_e selector,
    input  vehicle_pkg::accel_t    eff_accel,
    input  vehicle_pkg::speed_t    speed,
    output vehicle_pkg::gear_t     gear
);

    vehicle_pkg::gear_t gear_next;

    // ====================
    // next gear
    // ====================
    always_comb begin
        gear_next = gear;
        if (selector != vehicle_pkg::SEL_D) begin
            gear_next = 3'd1;
        end else if (eff_accel == '0) begin
            // gliding, gear follows the downshift table directly
            if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_12)) begin
                gear_next = 3'd1;
            end else if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_23)) begin
                gear_next = 3'd2;
            end else if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_34)) begin
                gear_next = 3'd3;
            end else if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_45)) begin
                gear_next = 3'd4;
            end else if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_56)) begin
                gear_next = 3'd5;
            end else begin
                gear_next = 3'd6;
            end
        end else begin
            // under load, shift up only past point plus hysteresis
            case (gear)
                3'd1: begin
                    if (speed >= vehicle_pkg::speed_t'(`VEH_SHIFT_12 + `VEH_SHIFT_HYST))
                        gear_next = 3'd2;
                end
                3'd2: begin
                    if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_12))
                        gear_next = 3'd1;
                    else if (speed >= vehicle_pkg::speed_t'(`VEH_SHIFT_23 + `VEH_SHIFT_HYST))
                        gear_next = 3'd3;
                end
                3'd3: begin
                    if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_23))
                        gear_next = 3'd2;
                    else if (speed >= vehicle_pkg::speed_t'(`VEH_SHIFT_34 + `VEH_SHIFT_HYST))
                        gear_next = 3'd4;
                end
                3'd4: begin
                    if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_34))
                        gear_next = 3'd3;
                    else if (speed >= vehicle_pkg::speed_t'(`VEH_SHIFT_45 + `VEH_SHIFT_HYST))
                        gear_next = 3'd5;
                end
                3'd5: begin
                    if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_45))
                        gear_next = 3'd4;
                    else if (speed >= vehicle_pkg::speed_t'(`VEH_SHIFT_56 + `VEH_SHIFT_HYST))
                        gear_next = 3'd6;
                end
                3'd6: begin
                    if (speed < vehicle_pkg::speed_t'(`VEH_SHIFT_56))
                        gear_next = 3'd5;
                end
                default: gear_next = 3'd1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gear <= 3'd1;
        end else if (coast_step) begin
            gear <= gear_next;
        end
    end

endmodule

`default_nettype wire

// File: source/rpm_calc.sv
`timescale 1ns/10ps
`default_nettype none

`include "vehicle_consts.svh"

module rpm_calc (
    input  vehicle_pkg::driver_s  driver,
    input  vehicle_pkg::speed_t   speed,
    input  vehicle_pkg::gear_t    gear,
    input  vehicle_pkg::accel_t   smooth_accel,
    input  logic [1:0]            jitter,
    output vehicle_pkg::rpm_t     rpm
);

    logic [7:0]  factor;
    logic [15:0] idle_rpm;
    logic [15:0] base_rpm;
    logic [15:0] drive_rpm;

    // ====================
    // rpm per state
    // ====================
    always_comb begin
        case (gear)
            3'd1:    factor = 8'(`VEH_RPM_FACTOR_G1);
            3'd2:    factor = 8'(`VEH_RPM_FACTOR_G2);
            3'd3:    factor = 8'(`VEH_RPM_FACTOR_G3);
            3'd4:    factor = 8'(`VEH_RPM_FACTOR_G4);
            3'd5:    factor = 8'(`VEH_RPM_FACTOR_G5);
            3'd6:    factor = 8'(`VEH_RPM_FACTOR_G6);
            default: factor = 8'd0;
        endcase

        // park and neutral rev freely on the raw pedal, limiter keeps the jitter
        idle_rpm = 16'(`VEH_IDLE_RPM) + 16'(driver.accel) * 16'(`VEH_IDLE_ACCEL_GAIN) +
                   16'(jitter);
        if (idle_rpm > 16'(`VEH_IDLE_RPM_MAX)) begin
            idle_rpm = 16'(`VEH_IDLE_RPM_MAX) + 16'(jitter);
        end

        // in gear, rpm is tied to road speed
        base_rpm = 16'(speed) * 16'(factor);
        if (base_rpm < 16'(`VEH_IDLE_RPM)) begin
            base_rpm = 16'(`VEH_IDLE_RPM);
        end
        if (base_rpm > 16'(`VEH_RPM_BASE_MAX)) begin
            base_rpm = 16'(`VEH_IDLE_RPM);
        end
        // converter slip under throttle adds a little on top
        drive_rpm = base_rpm + {7'd0, smooth_accel, 1'b0} + 16'(jitter);
        if (drive_rpm > 16'(`VEH_DRIVE_RPM_MAX)) begin
            drive_rpm = 16'(`VEH_DRIVE_RPM_MAX);
        end

        if (!driver.engine_on) begin
            rpm = '0;
        end else if (driver.selector == vehicle_pkg::SEL_P ||
                     driver.selector == vehicle_pkg::SEL_N) begin
            rpm = vehicle_pkg::rpm_t'(idle_rpm);
        end else begin
            rpm = vehicle_pkg::rpm_t'(drive_rpm);
        end
    end

endmodule

`default_nettype wire

// File: source/vehicle_top.sv
`timescale 1ns/10ps
`default_nettype none

module vehicle_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   tick_speed,
    input  vehicle_pkg::driver_s  driver,
    output vehicle_pkg::speed_t   speed,
    output vehicle_pkg::rpm_t     rpm,
    output vehicle_pkg::gear_t    gear,
    output logic                  ess
);

    vehicle_pkg::accel_t eff_accel;
    vehicle_pkg::accel_t smooth_accel;
    logic [1:0]          jitter;
    logic                coast_step;

    // ====================
    // pedal path
    // ====================
    throttle_filter u_throttle (
        .clk          (clk),
        .rst          (rst),
        .tick_speed   (tick_speed),
        .accel        (driver.accel),
        .eff_accel    (eff_accel),
        .smooth_accel (smooth_accel),
        .jitter       (jitter)
    );

    // ====================
    // vehicle motion
    // ====================
    speed_dynamics u_speed (
        .clk        (clk),
        .rst        (rst),
        .tick_speed (tick_speed),
        .driver     (driver),
        .eff_accel  (eff_accel),
        .gear       (gear),
        .rpm        (rpm),
        .speed      (speed),
        .ess        (ess),
        .coast_step (coast_step)
    );

    // gear is chosen one cycle after speed settles
    gear_selector u_gear (
        .clk        (clk),
        .rst        (rst),
        .coast_step (coast_step),
        .selector   (driver.selector),
        .eff_accel  (eff_accel),
        .speed      (speed),
        .gear       (gear)
    );

    // rpm loops back into speed_dynamics for the redline gate
    rpm_calc u_rpm (
        .driver       (driver),
        .speed        (speed),
        .gear         (gear),
        .smooth_accel (smooth_accel),
        .jitter       (jitter),
        .rpm          (rpm)
    );

endmodule

`default_nettype wire

// File: dv/vehicle_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "vehicle_consts.svh"

module vehicle_chk (
    input wire                   clk,
    input wire                   rst,
    input wire                   tick_speed,
    input vehicle_pkg::driver_s  driver,
    input vehicle_pkg::speed_t   speed,
    input vehicle_pkg::rpm_t     rpm,
    input vehicle_pkg::gear_t    gear,
    input wire                   ess
);

    // ess rises only on a hard brake tick and any other tick clears it
    ess_needs_hard_brake: assert property (
        @(posedge clk) disable iff (rst)
        (ess && ($past(tick_speed) || !$past(ess))) |->
            $past(tick_speed && driver.brake_hard)
    ) else $error("ess high without a hard brake at the last tick");

    gear_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (gear >= 3'd1) && (gear <= 3'd6)
    ) else $error("gear %0d outside 1 to 6", gear);

    drive_rpm_clamped: assert property (
        @(posedge clk) disable iff (rst)
        (driver.engine_on && driver.selector == vehicle_pkg::SEL_D) |->
            (rpm <= vehicle_pkg::rpm_t'(`VEH_DRIVE_RPM_MAX))
    ) else $error("rpm %0d above the drive clamp", rpm);

    // speed register only loads on the tick strobe
    speed_moves_on_tick: assert property (
        @(posedge clk) disable iff (rst)
        (speed != $past(speed)) |-> $past(tick_speed)
    ) else $error("speed changed without a tick");

endmodule

`default_nettype wire

// File: dv/vehicle_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vehicle_tb;

    localparam int MAX_STEPS = 32;

    // one pattern line
    typedef struct packed {
        vehicle_pkg::driver_s drv;
        logic [7:0]           ticks;
        vehicle_pkg::speed_t  exp_speed;
        vehicle_pkg::gear_t   exp_gear;
        logic                 exp_ess;
        logic                 check_rpm;
        vehicle_pkg::rpm_t    exp_rpm;
    } step_s;

    logic                 clk;
    logic                 rst;
    logic                 tick_speed;
    vehicle_pkg::driver_s driver;
    vehicle_pkg::speed_t  speed;
    vehicle_pkg::rpm_t    rpm;
    vehicle_pkg::gear_t   gear;
    logic                 ess;

    step_s steps[MAX_STEPS];
    string step_names[MAX_STEPS];
    int    num_steps;
    int    total_ticks;
    int    ticks_issued;
    int    load_errors;
    int    tests_failed;
    int    watchdog_ns;
    bit    steps_loaded;

    vehicle_top uut (
        .clk        (clk),
        .rst        (rst),
        .tick_speed (tick_speed),
        .driver     (driver),
        .speed      (speed),
        .rpm        (rpm),
        .gear       (gear),
        .ess        (ess)
    );

    bind vehicle_top vehicle_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .tick_speed (tick_speed),
        .driver     (driver),
        .speed      (speed),
        .rpm        (rpm),
        .gear       (gear),
        .ess        (ess)
    );

    always #10 clk = ~clk;

    // digits of a text field, anything else is skipped
    function automatic int to_number(input logic [63:0] txt);
        int         value;
        logic [7:0] ch;
        value = 0;
        for (int b = 7; b >= 0; b--) begin
            ch = txt[b*8 +: 8];
            if (ch >= "0" && ch <= "9") begin
                value = value * 10 + int'(ch) - 48;
            end
        end
        return value;
    endfunction

    // ====================
    // pattern file
    // ====================
    task automatic load_steps();
        int                     fd;
        int                     n;
        int                     eng;
        int                     acc;
        int                     bn;
        int                     bh;
        int                     ticks_i;
        int                     e_speed;
        int                     e_gear;
        int                     e_ess;
        string                  line;
        logic [159:0]           name_txt;
        logic [7:0]             sel_txt;
        logic [63:0]            rpm_txt;
        vehicle_pkg::gear_sel_e sel;
        step_s                  st;
        fd = $fopen("dv/vehicle_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/vehicle_patterns.txt");
            load_errors++;
            return;
        end
        while (!$feof(fd) && num_steps < MAX_STEPS) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
            n = $sscanf(line, "%s %d %s %d %d %d %d %d %d %d %s", name_txt, eng, sel_txt,
                        acc, bn, bh, ticks_i, e_speed, e_gear, e_ess, rpm_txt);
            if (n != 11) begin
                $display("malformed pattern line: %s", line);
                load_errors++;
                continue;
            end
            sel = vehicle_pkg::SEL_P;
            case (sel_txt)
                "P": sel = vehicle_pkg::SEL_P;
                "R": sel = vehicle_pkg::SEL_R;
                "N": sel = vehicle_pkg::SEL_N;
                "D": sel = vehicle_pkg::SEL_D;
                default: begin
                    $display("unknown selector letter in pattern line: %s", line);
                    load_errors++;
                end
            endcase
            st.drv.engine_on    = eng[0];
            st.drv.selector     = sel;
            st.drv.accel        = vehicle_pkg::accel_t'(acc);
            st.drv.brake_normal = bn[0];
            st.drv.brake_hard   = bh[0];
            st.ticks            = 8'(ticks_i);
            st.exp_speed        = vehicle_pkg::speed_t'(e_speed);
            st.exp_gear         = vehicle_pkg::gear_t'(e_gear);
            st.exp_ess          = e_ess[0];
            st.check_rpm        = (rpm_txt != 64'("-"));
            st.exp_rpm          = vehicle_pkg::rpm_t'(to_number(rpm_txt));
            steps[num_steps]      = st;
            step_names[num_steps] = $sformatf("%0s", name_txt);
            total_ticks += ticks_i;
            num_steps++;
        end
        $fclose(fd);
    endtask

    // ====================
    // one test step
    // ====================
    task automatic run_step(input int idx);
        step_s             st;
        vehicle_pkg::rpm_t want_rpm;
        bit                ok;
        st = steps[idx];
        ok = 1'b1;
        @(negedge clk);
        driver = st.drv;
        @(negedge clk);
        // each tick is a single-cycle strobe, then three quiet cycles
        for (int t = 0; t < int'(st.ticks); t++) begin
            tick_speed = 1'b1;
            @(negedge clk);
            tick_speed = 1'b0;
            ticks_issued++;
            repeat (3) @(negedge clk);
        end
        // engine jitter follows the tick count
        want_rpm = st.exp_rpm;
        if (st.drv.engine_on) begin
            want_rpm = st.exp_rpm + vehicle_pkg::rpm_t'(ticks_issued % 4);
        end
        assert (speed == st.exp_speed) else begin
            $display("Fail %0s speed expected %0d actual %0d", step_names[idx], st.exp_speed, speed);
            ok = 1'b0;
        end
        assert (gear == st.exp_gear) else begin
            $display("Fail %0s gear expected %0d actual %0d", step_names[idx], st.exp_gear, gear);
            ok = 1'b0;
        end
        assert (ess == st.exp_ess) else begin
            $display("Fail %0s ess expected %0d actual %0d", step_names[idx], st.exp_ess, ess);
            ok = 1'b0;
        end
        assert (!st.check_rpm || rpm == want_rpm) else begin
            $display("Fail %0s rpm expected %0d actual %0d", step_names[idx], want_rpm, rpm);
            ok = 1'b0;
        end
        if (ok) begin
            $display("test %0s ok", step_names[idx]);
        end else begin
            $display("test %0s wrong", step_names[idx]);
            tests_failed++;
        end
    endtask

    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        tick_speed          = 1'b0;
        driver.engine_on    = 1'b0;
        driver.selector     = vehicle_pkg::SEL_P;
        driver.accel        = '0;
        driver.brake_normal = 1'b0;
        driver.brake_hard   = 1'b0;
        num_steps           = 0;
        total_ticks         = 0;
        ticks_issued        = 0;
        load_errors         = 0;
        tests_failed        = 0;
        load_steps();
        watchdog_ns  = total_ticks * 80 + 20 * (2 * num_steps + 10) + 2000;
        steps_loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_steps; i++) begin
            run_step(i);
        end
        $display("tests %0d, passed %0d, failed %0d, pattern errors %0d", num_steps,
                 num_steps - tests_failed, tests_failed, load_errors);
        if (tests_failed == 0 && load_errors == 0 && num_steps > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog sized from the tick count in the pattern file
    initial begin
        wait (steps_loaded);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
source/vehicle_pkg.sv
source/throttle_filter.sv
source/speed_dynamics.sv
source/gear_selector.sv
source/rpm_calc.sv
source/vehicle_top.sv
dv/vehicle_chk.sv
dv/vehicle_tb.sv

// File: run.sh
#!/bin/sh
# build the vehicle testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module vehicle_tb; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vvehicle_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'ALL CHECKS PASSED'; then
    exit 0
fi

echo "simulation did not report success"
exit 1

// File: dv/vehicle_patterns.txt
# name engine selector(P/R/N/D) accel brake_normal brake_hard ticks speed gear ess rpm
# rpm excludes the tick jitter, a dash skips the rpm check
reset_idle       0 P   0 0 0  0   0 1 0    0
park_rev         1 P 100 0 0  3   0 1 0 2800
park_limit       1 P 255 0 0  2   0 1 0 4000
drive_accel      1 D 255 0 0 30  30 2 0 2300
drive_to_60      1 D 255 0 0 30  60 4 0 2300
hard_brake       1 D   0 0 1  1  52 4 1 2044
normal_brake     1 D   0 1 0  1  49 4 0 1938
hard_brake_slow  1 D   0 0 1  1  41 4 0 1682
brake_down       1 D   0 1 0  7  20 4 0    -
glide_gear2      1 D   0 0 0  1  20 2 0 1524
glide_gear1      1 D   0 0 0  3  19 1 0 2176
coast_g1         1 D   0 0 0  6  16 1 0 1780
stop             1 D   0 1 0  6   0 1 0  884
reverse_climb    1 R 255 0 0 40  40 1 0 4500
reverse_hold     1 R 255 0 0 20  50 1 0 5500
engine_off       0 N   0 0 0  2  49 1 0    0
